// ==== source/rom_loader_pkg.sv ====
/*
 * shared definitions for the ROM loading path
 * FSM state enums, cartridge header constants, mapper flag field positions
 */

package rom_loader_pkg;

  // host word intake FSM
  typedef enum logic {
    INTAKE_IDLE,
    INTAKE_ACK
  } intake_state_t;

  // cartridge parser FSM
  typedef enum logic [2:0] {
    P_HUNT,
    P_MAGIC,
    P_HEADER,
    P_PRG,
    P_CHR,
    P_DONE,
    P_FAIL
  } parser_state_t;

  // header magic, "NES" followed by end of file
  localparam logic [7:0] MAGIC_N = 8'h4E;
  localparam logic [7:0] MAGIC_E = 8'h45;
  localparam logic [7:0] MAGIC_S = 8'h53;
  localparam logic [7:0] MAGIC_EOF = 8'h1A;

  localparam int HEADER_BYTES = 16;

  // console memory map
  localparam int MEM_ADDR_W = 22;
  localparam logic [MEM_ADDR_W-1:0] CHR_BASE = 22'h200000;

  // mapper flags word layout, unlisted bits stay zero
  localparam int MF_MAPPER_LSB = 0;
  localparam int MF_PRG_LSB = 8;
  localparam int MF_CHR_LSB = 16;
  localparam int MF_VMIRROR_BIT = 24;
  localparam int MF_BATTERY_BIT = 25;
  localparam int MF_FOUR_SCREEN_BIT = 26;

endpackage

// ==== source/boot_word_intake.sv ====
/*
 * host boot word intake
 * req/ack handshake with a one-cycle ack pulse, drops words past rom_size
 */

`timescale 1ns/1ps

module boot_word_intake (
  input  logic        clk,
  input  logic        host_reset_loader,
  input  logic [31:0] bootdata,
  input  logic        bootdata_req,
  output logic        bootdata_ack,
  input  logic [31:0] rom_size,
  output logic        word_valid,
  output logic [31:0] word_data,
  input  logic        word_ready
);

  rom_loader_pkg::intake_state_t state;
  logic [31:0] bytes_loaded;
  logic        word_keep;

  // words beyond the declared image are acked but not forwarded
  assign word_keep = bytes_loaded < rom_size;

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      state        <= rom_loader_pkg::INTAKE_IDLE;
      bootdata_ack <= 1'b0;
      word_valid   <= 1'b0;
      bytes_loaded <= 32'd0;
    end else begin
      if (word_valid && word_ready) begin
        word_valid <= 1'b0;
      end
      case (state)
        rom_loader_pkg::INTAKE_IDLE: begin
          // no ack while the downstream buffer is full
          if (bootdata_req && word_ready && !word_valid) begin
            state        <= rom_loader_pkg::INTAKE_ACK;
            bootdata_ack <= 1'b1;
            word_valid   <= word_keep;
            if (word_keep) begin
              bytes_loaded <= bytes_loaded + 32'd4;
            end
          end
        end
        rom_loader_pkg::INTAKE_ACK: begin
          // ack pulse ends, host drops req before the next word
          bootdata_ack <= 1'b0;
          state        <= rom_loader_pkg::INTAKE_IDLE;
        end
        default: begin
          state <= rom_loader_pkg::INTAKE_IDLE;
        end
      endcase
    end
  end

  // word register, loaded together with the ack
  always_ff @(posedge clk) begin
    if (state == rom_loader_pkg::INTAKE_IDLE && bootdata_req && word_ready && !word_valid) begin
      word_data <= bootdata;
    end
  end

  // host must see a single-cycle ack per request
  ack_single_pulse: assert property (
    @(posedge clk) disable iff (host_reset_loader)
    bootdata_ack |=> !bootdata_ack
  );

endmodule

// ==== source/word_unpacker.sv ====
/*
 * circular word buffer feeding a byte stream
 * bytes leave least significant first, the word pops after lane 3
 */

`timescale 1ns/1ps

module word_unpacker #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        host_reset_loader,
  input  logic        word_valid,
  input  logic [31:0] word_data,
  output logic        word_ready,
  output logic        byte_valid,
  output logic [7:0]  byte_data,
  input  logic        byte_ready
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  logic [31:0]      fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [1:0]       lane;
  logic             push;
  logic             pop;

  assign word_ready = count != FULL_CNT;
  assign byte_valid = count != '0;

  // current lane of the head word
  assign byte_data = fifo_mem[rd_ptr][{lane, 3'b000} +: 8];

  assign push = word_valid && word_ready;
  assign pop  = byte_valid && byte_ready && (lane == 2'd3);

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= word_data;
    end
  end

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      lane   <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + PTR_W'(1);
      end
      // lane wraps back to 0 on the pop
      if (byte_valid && byte_ready) begin
        lane <= lane + 2'd1;
      end
      if (push && !pop) begin
        count <= count + CNT_W'(1);
      end else if (pop && !push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  // a full buffer must hold off the intake
  no_write_when_full: assert property (
    @(posedge clk) disable iff (host_reset_loader)
    word_valid |-> word_ready
  );

endmodule

// ==== source/ines_parser.sv ====
/*
 * cartridge header parser and payload writer
 * hunts for the magic, decodes mapper flags, writes PRG then CHR bytes to memory
 */

`timescale 1ns/1ps

module ines_parser #(
  parameter int PRG_BANK_BYTES = 16384
) (
  input  logic                                clk,
  input  logic                                host_reset_loader,
  input  logic                                byte_valid,
  input  logic [7:0]                          byte_data,
  output logic                                byte_ready,
  output logic                                mem_valid,
  output logic [rom_loader_pkg::MEM_ADDR_W-1:0] mem_addr,
  output logic [7:0]                          mem_data,
  input  logic                                mem_ready,
  output logic [31:0]                         mapper_flags,
  output logic                                loader_done,
  output logic                                loader_fail
);

  localparam int ADDR_W = rom_loader_pkg::MEM_ADDR_W;
  localparam logic [31:0] PRG_BANK_SIZE = 32'(PRG_BANK_BYTES);
  localparam logic [31:0] CHR_BANK_SIZE = 32'(PRG_BANK_BYTES / 2);
  localparam logic [3:0] LAST_HDR_IDX = 4'(rom_loader_pkg::HEADER_BYTES - 1);

  rom_loader_pkg::parser_state_t state;
  logic [3:0]  hdr_idx;
  logic [7:0]  prg_banks;
  logic [7:0]  chr_banks;
  logic [7:0]  flags6;
  logic [7:0]  flags7;
  logic [31:0] seg_left;
  logic [31:0] hdr_flags;
  logic [7:0]  magic_exp;
  logic        byte_take;
  logic        mem_take;

  // payload waits for the pending write, everything else is taken at once
  always_comb begin
    case (state)
      rom_loader_pkg::P_PRG,
      rom_loader_pkg::P_CHR: byte_ready = !mem_valid && (seg_left != 32'd0);
      default:               byte_ready = 1'b1;
    endcase
  end

  assign byte_take   = byte_valid && byte_ready;
  assign mem_take    = mem_valid && mem_ready;
  assign loader_done = state == rom_loader_pkg::P_DONE;
  assign loader_fail = state == rom_loader_pkg::P_FAIL;

  // magic byte expected after the leading N
  always_comb begin
    case (hdr_idx[1:0])
      2'd1:    magic_exp = rom_loader_pkg::MAGIC_E;
      2'd2:    magic_exp = rom_loader_pkg::MAGIC_S;
      default: magic_exp = rom_loader_pkg::MAGIC_EOF;
    endcase
  end

  // mapper number is byte 7 high nibble over byte 6 high nibble
  always_comb begin
    hdr_flags = 32'd0;
    hdr_flags[rom_loader_pkg::MF_MAPPER_LSB +: 8] = {flags7[7:4], flags6[7:4]};
    hdr_flags[rom_loader_pkg::MF_PRG_LSB +: 8] = prg_banks;
    hdr_flags[rom_loader_pkg::MF_CHR_LSB +: 8] = chr_banks;
    hdr_flags[rom_loader_pkg::MF_VMIRROR_BIT] = flags6[0];
    hdr_flags[rom_loader_pkg::MF_BATTERY_BIT] = flags6[1];
    hdr_flags[rom_loader_pkg::MF_FOUR_SCREEN_BIT] = flags6[3];
  end

  // header fields 4 to 7
  always_ff @(posedge clk) begin
    if (state == rom_loader_pkg::P_HEADER && byte_take) begin
      case (hdr_idx)
        4'd4:    prg_banks <= byte_data;
        4'd5:    chr_banks <= byte_data;
        4'd6:    flags6 <= byte_data;
        4'd7:    flags7 <= byte_data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      state        <= rom_loader_pkg::P_HUNT;
      hdr_idx      <= 4'd0;
      seg_left     <= 32'd0;
      mem_valid    <= 1'b0;
      mapper_flags <= 32'd0;
    end else begin
      if (mem_take) begin
        mem_valid <= 1'b0;
        mem_addr  <= mem_addr + ADDR_W'(1);
      end
      case (state)
        rom_loader_pkg::P_HUNT: begin
          // skip leading junk up to the N
          if (byte_take && byte_data == rom_loader_pkg::MAGIC_N) begin
            state   <= rom_loader_pkg::P_MAGIC;
            hdr_idx <= 4'd1;
          end
        end
        rom_loader_pkg::P_MAGIC: begin
          if (byte_take) begin
            if (byte_data != magic_exp) begin
              state <= rom_loader_pkg::P_FAIL;
            end else begin
              hdr_idx <= hdr_idx + 4'd1;
              if (hdr_idx == 4'd3) begin
                state <= rom_loader_pkg::P_HEADER;
              end
            end
          end
        end
        rom_loader_pkg::P_HEADER: begin
          if (byte_take) begin
            hdr_idx <= hdr_idx + 4'd1;
            if (hdr_idx == 4'd4 && byte_data == 8'd0) begin
              // an image without PRG is unusable
              state <= rom_loader_pkg::P_FAIL;
            end else if (hdr_idx == LAST_HDR_IDX) begin
              mapper_flags <= hdr_flags;
              seg_left     <= {24'd0, prg_banks} * PRG_BANK_SIZE;
              mem_addr     <= '0;
              state        <= rom_loader_pkg::P_PRG;
            end
          end
        end
        rom_loader_pkg::P_PRG,
        rom_loader_pkg::P_CHR: begin
          if (byte_take) begin
            mem_valid <= 1'b1;
            mem_data  <= byte_data;
            seg_left  <= seg_left - 32'd1;
          end
          // segment ends once its last write has been accepted
          if (mem_take && seg_left == 32'd0) begin
            if (state == rom_loader_pkg::P_CHR || chr_banks == 8'd0) begin
              state <= rom_loader_pkg::P_DONE;
            end else begin
              state    <= rom_loader_pkg::P_CHR;
              seg_left <= {24'd0, chr_banks} * CHR_BANK_SIZE;
              mem_addr <= rom_loader_pkg::CHR_BASE;
            end
          end
        end
        default: ;
      endcase
    end
  end

  // memory port holds its address through a stall
  mem_addr_stable: assert property (
    @(posedge clk) disable iff (host_reset_loader)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
  );

endmodule

// ==== source/rom_loader_top.sv ====
/*
 * ROM loader top level
 * host intake, word to byte unpacker and cartridge parser in a pipeline
 */

`timescale 1ns/1ps

module rom_loader_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int PRG_BANK_BYTES = 16384
) (
  input  logic                                clk,
  input  logic                                host_reset_loader,
  input  logic [31:0]                         bootdata,
  input  logic                                bootdata_req,
  output logic                                bootdata_ack,
  input  logic [31:0]                         rom_size,
  output logic                                mem_valid,
  output logic [rom_loader_pkg::MEM_ADDR_W-1:0] mem_addr,
  output logic [7:0]                          mem_data,
  input  logic                                mem_ready,
  output logic [31:0]                         mapper_flags,
  output logic                                loader_done,
  output logic                                loader_fail
);

  // intake to unpacker
  logic        word_valid;
  logic [31:0] word_data;
  logic        word_ready;

  // unpacker to parser
  logic        byte_valid;
  logic [7:0]  byte_data;
  logic        byte_ready;

  boot_word_intake u_intake (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .bootdata          (bootdata),
    .bootdata_req      (bootdata_req),
    .bootdata_ack      (bootdata_ack),
    .rom_size          (rom_size),
    .word_valid        (word_valid),
    .word_data         (word_data),
    .word_ready        (word_ready)
  );

  word_unpacker #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_unpacker (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .word_valid        (word_valid),
    .word_data         (word_data),
    .word_ready        (word_ready),
    .byte_valid        (byte_valid),
    .byte_data         (byte_data),
    .byte_ready        (byte_ready)
  );

  ines_parser #(
    .PRG_BANK_BYTES (PRG_BANK_BYTES)
  ) u_parser (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .byte_valid        (byte_valid),
    .byte_data         (byte_data),
    .byte_ready        (byte_ready),
    .mem_valid         (mem_valid),
    .mem_addr          (mem_addr),
    .mem_data          (mem_data),
    .mem_ready         (mem_ready),
    .mapper_flags      (mapper_flags),
    .loader_done       (loader_done),
    .loader_fail       (loader_fail)
  );

endmodule

// ==== verif/rom_loader_tb.sv ====
/*
 * testbench for the ROM loader top level
 * random cartridge images, host and memory models, compare tasks, watchdog
 */

`timescale 1ns/1ps

module rom_loader_tb;

  localparam int CLK_PERIOD = 4;
  localparam int SEED = 15191;
  localparam int PRG_BANK = 64;
  localparam int CHR_BANK = PRG_BANK / 2;
  localparam int NUM_TESTS = 12;
  // worst case image: junk, header, 3 PRG and 2 CHR banks, padding, trailing words
  localparam int MAX_IMAGE_BYTES = 8 + 16 + 3 * PRG_BANK + 2 * CHR_BANK + 4 + 16;
  localparam int WATCHDOG_NS = (NUM_TESTS * MAX_IMAGE_BYTES * 40 + 2000) * CLK_PERIOD;
  localparam int ADDR_W = rom_loader_pkg::MEM_ADDR_W;

  logic              clk = 1'b0;
  logic              host_reset_loader = 1'b1;
  logic [31:0]       bootdata = 32'd0;
  logic              bootdata_req = 1'b0;
  logic              bootdata_ack;
  logic [31:0]       rom_size = 32'd0;
  logic              mem_valid;
  logic [ADDR_W-1:0] mem_addr;
  logic [7:0]        mem_data;
  logic              mem_ready = 1'b0;
  logic [31:0]       mapper_flags;
  logic              loader_done;
  logic              loader_fail;

  // image and expected results of the current test
  logic [7:0]        img[$];
  logic [31:0]       words[$];
  logic [ADDR_W-1:0] exp_addr[$];
  logic [7:0]        exp_data[$];
  logic [31:0]       exp_flags;
  logic              exp_done;
  logic              exp_fail;

  // observed memory writes
  logic [ADDR_W-1:0] got_addr[$];
  logic [7:0]        got_data[$];
  bit                seen_addr[int];
  bit                dup_write;
  int                ack_count;

  bit stall_on = 1'b0;
  int gap_max = 0;
  int test_errs;
  int test_num = 0;
  int pass_count = 0;
  int fail_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rom_loader_top #(
    .FIFO_DEPTH     (4),
    .PRG_BANK_BYTES (PRG_BANK)
  ) dut0 (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .bootdata          (bootdata),
    .bootdata_req      (bootdata_req),
    .bootdata_ack      (bootdata_ack),
    .rom_size          (rom_size),
    .mem_valid         (mem_valid),
    .mem_addr          (mem_addr),
    .mem_data          (mem_data),
    .mem_ready         (mem_ready),
    .mapper_flags      (mapper_flags),
    .loader_done       (loader_done),
    .loader_fail       (loader_fail)
  );

  // memory side: random ready, write capture, ack counting
  always @(negedge clk) begin
    if (host_reset_loader) begin
      got_addr.delete();
      got_data.delete();
      seen_addr.delete();
      dup_write = 1'b0;
      ack_count = 0;
    end
    mem_ready = stall_on ? (($urandom % 4) != 0) : 1'b1;
    // write lands at the coming rising edge
    if (!host_reset_loader && mem_valid && mem_ready) begin
      if (seen_addr.exists(int'(mem_addr))) begin
        dup_write = 1'b1;
      end
      seen_addr[int'(mem_addr)] = 1'b1;
      got_addr.push_back(mem_addr);
      got_data.push_back(mem_data);
    end
    if (!host_reset_loader && bootdata_ack) begin
      ack_count++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the loader stopped making progress", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  task automatic build_image(input int junk_n, input int prg_banks, input int chr_banks,
                             input int bad_magic, input int trail_words);
    logic [7:0] hdr[$];
    logic [7:0] b;
    int         i;
    img.delete();
    words.delete();
    exp_addr.delete();
    exp_data.delete();
    for (i = 0; i < junk_n; i++) begin
      // junk never looks like the start of a header
      do begin
        b = 8'($urandom);
      end while (b == rom_loader_pkg::MAGIC_N);
      img.push_back(b);
    end
    hdr.push_back(rom_loader_pkg::MAGIC_N);
    hdr.push_back(rom_loader_pkg::MAGIC_E);
    hdr.push_back(rom_loader_pkg::MAGIC_S);
    hdr.push_back(rom_loader_pkg::MAGIC_EOF);
    hdr.push_back(8'(prg_banks));
    hdr.push_back(8'(chr_banks));
    for (i = 6; i < rom_loader_pkg::HEADER_BYTES; i++) begin
      hdr.push_back(8'($urandom));
    end
    if (bad_magic != 0) begin
      hdr[bad_magic] = hdr[bad_magic] ^ 8'(1 + ($urandom % 255));
    end
    foreach (hdr[k]) begin
      img.push_back(hdr[k]);
    end
    for (i = 0; i < prg_banks * PRG_BANK; i++) begin
      b = 8'($urandom);
      img.push_back(b);
      exp_addr.push_back(ADDR_W'(i));
      exp_data.push_back(b);
    end
    for (i = 0; i < chr_banks * CHR_BANK; i++) begin
      b = 8'($urandom);
      img.push_back(b);
      exp_addr.push_back(rom_loader_pkg::CHR_BASE + ADDR_W'(i));
      exp_data.push_back(b);
    end
    rom_size = 32'(img.size());
    // fill the last word, then pack least significant byte first
    while (img.size() % 4 != 0) begin
      img.push_back(8'($urandom));
    end
    for (i = 0; i < img.size(); i += 4) begin
      words.push_back({img[i+3], img[i+2], img[i+1], img[i]});
    end
    for (i = 0; i < trail_words; i++) begin
      words.push_back($urandom);
    end
    exp_flags = 32'd0;
    if (bad_magic != 0 || prg_banks == 0) begin
      exp_done = 1'b0;
      exp_fail = 1'b1;
      exp_addr.delete();
      exp_data.delete();
    end else begin
      exp_done = 1'b1;
      exp_fail = 1'b0;
      exp_flags[rom_loader_pkg::MF_MAPPER_LSB +: 8] = {hdr[7][7:4], hdr[6][7:4]};
      exp_flags[rom_loader_pkg::MF_PRG_LSB +: 8] = hdr[4];
      exp_flags[rom_loader_pkg::MF_CHR_LSB +: 8] = hdr[5];
      exp_flags[rom_loader_pkg::MF_VMIRROR_BIT] = hdr[6][0];
      exp_flags[rom_loader_pkg::MF_BATTERY_BIT] = hdr[6][1];
      exp_flags[rom_loader_pkg::MF_FOUR_SCREEN_BIT] = hdr[6][3];
    end
  endtask

  task automatic apply_reset();
    host_reset_loader = 1'b1;
    repeat (3) @(negedge clk);
    host_reset_loader = 1'b0;
  endtask

  // host side of the req/ack handshake
  task automatic send_image();
    int gap;
    foreach (words[i]) begin
      bootdata = words[i];
      bootdata_req = 1'b1;
      @(negedge clk);
      while (!bootdata_ack) begin
        @(negedge clk);
      end
      bootdata_req = 1'b0;
      gap = (gap_max > 0) ? int'($urandom % (gap_max + 1)) : 0;
      repeat (1 + gap) @(negedge clk);
    end
  endtask

  task automatic check_flags(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] mapper_flags: got 0x%08h expected 0x%08h", got, exp);
      test_errs++;
    end
  endtask

  task automatic check_write(input int idx, input logic [ADDR_W-1:0] got_a,
                             input logic [ADDR_W-1:0] exp_a, input logic [7:0] got_d,
                             input logic [7:0] exp_d);
    if (got_a !== exp_a) begin
      $display("[ERROR] mem_addr (write %0d): got 0x%06h expected 0x%06h", idx, got_a, exp_a);
      test_errs++;
    end
    if (got_d !== exp_d) begin
      $display("[ERROR] mem_data (write %0d): got 0x%02h expected 0x%02h", idx, got_d, exp_d);
      test_errs++;
    end
  endtask

  task automatic check_status(input logic got_done, input logic got_fail,
                              input logic exp_d, input logic exp_f);
    if (got_done !== exp_d) begin
      $display("[ERROR] loader_done: got 0x%0h expected 0x%0h", got_done, exp_d);
      test_errs++;
    end
    if (got_fail !== exp_f) begin
      $display("[ERROR] loader_fail: got 0x%0h expected 0x%0h", got_fail, exp_f);
      test_errs++;
    end
  endtask

  task automatic compare_writes();
    int n;
    n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      check_write(i, got_addr[i], exp_addr[i], got_data[i], exp_data[i]);
    end
    if (got_addr.size() < exp_addr.size()) begin
      $display("memory writes missing: only %0d of %0d writes arrived",
               got_addr.size(), exp_addr.size());
      test_errs++;
    end else if (got_addr.size() > exp_addr.size()) begin
      $display("extra memory writes: %0d arrived, %0d expected",
               got_addr.size(), exp_addr.size());
      test_errs++;
    end
    if (dup_write) begin
      $display("a memory address was written more than once");
      test_errs++;
    end
  endtask

  task automatic run_test(input string name, input int junk_n, input int prg_banks,
                          input int chr_banks, input int bad_magic, input int trail_words);
    test_errs = 0;
    build_image(junk_n, prg_banks, chr_banks, bad_magic, trail_words);
    apply_reset();
    check_status(loader_done, loader_fail, 1'b0, 1'b0);
    check_flags(mapper_flags, 32'd0);
    if (bootdata_ack !== 1'b0 || mem_valid !== 1'b0) begin
      $display("ack or memory valid still active after reset");
      test_errs++;
    end
    send_image();
    while (!(loader_done || loader_fail)) begin
      @(negedge clk);
    end
    check_status(loader_done, loader_fail, exp_done, exp_fail);
    check_flags(mapper_flags, exp_flags);
    compare_writes();
    if (ack_count != words.size()) begin
      $display("host saw %0d acks for %0d requests", ack_count, words.size());
      test_errs++;
    end
    test_num++;
    if (test_errs == 0) begin
      pass_count++;
      $display("test %0d %s: ok, %0d writes", test_num, name, got_addr.size());
    end else begin
      fail_count++;
      $display("test %0d %s: %0d mismatches", test_num, name, test_errs);
    end
  endtask

  initial begin
    int junk;
    int prg;
    int chr;
    int trail;
    void'($urandom(SEED));
    @(negedge clk);

    run_test("valid_no_junk", 0, 2, 1, 0, 0);

    gap_max = 2;
    stall_on = 1'b1;
    junk = 1 + int'($urandom % 7);
    trail = 1 + int'($urandom % 4);
    run_test("junk_and_trailing", junk, 1, 2, 0, trail);

    // each magic byte after the N corrupted in turn
    for (int m = 1; m <= 3; m++) begin
      junk = int'($urandom % 8);
      run_test("bad_magic", junk, 1, 1, m, 0);
    end
    run_test("zero_prg", 3, 0, 1, 0, 0);
    run_test("zero_chr", 2, 2, 0, 0, 1);

    gap_max = 3;
    for (int r = 0; r < 5; r++) begin
      junk = int'($urandom % 8);
      prg = 1 + int'($urandom % 3);
      chr = int'($urandom % 3);
      trail = int'($urandom % 4);
      run_test("random_stalls", junk, prg, chr, 0, trail);
    end

    $display("summary: %0d tests, %0d without errors, %0d with errors",
             test_num, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== rom_loader.f ====
source/rom_loader_pkg.sv
source/boot_word_intake.sv
source/word_unpacker.sv
source/ines_parser.sv
source/rom_loader_top.sv
verif/rom_loader_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ROM loader testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert \
  --top-module rom_loader_tb \
  -f rom_loader.f \
  --Mdir "$BUILD_DIR" \
  -o rom_loader_sim

"./$BUILD_DIR/rom_loader_sim" | tee "$LOG_FILE"

if grep -q "^Test passed$" "$LOG_FILE"; then
  echo "simulation finished without errors"
  exit 0
else
  echo "simulation reported errors, see $LOG_FILE"
  exit 1
fi
